// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_eeprom_ctrl
DUT_TOP   ?= eeprom_ctrl_top
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== apb_eeprom_regs.sv ====
`timescale 1ns/1ns
module apb_eeprom_regs #(
    parameter int APB_ADDR_W = 4
) (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [APB_ADDR_W-1:0] paddr,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr,
    input  logic                  busy,
    input  logic                  done,
    input  logic                  nack,
    input  logic [7:0]            rd_data,
    output logic                  start,
    output logic                  rnw,
    output logic [10:0]           mem_addr,
    output logic [7:0]            wr_data
);
    import apb_regs_pkg::*;

    logic       cmd_sel;
    logic       status_sel;
    logic       cmd_wr;
    logic       cmd_accept;
    logic       nack_q;
    logic [7:0] rd_data_q;

    assign cmd_sel    = paddr == APB_ADDR_W'(reg_cmd_offset);
    assign status_sel = paddr == APB_ADDR_W'(reg_status_offset);
    assign cmd_wr     = psel && penable && pwrite && cmd_sel;

    // start runs one cycle ahead of the sequencer's busy
    assign cmd_accept = cmd_wr && !busy && !start;

    assign pready  = 1'b1;             // no wait states
    assign pslverr = cmd_wr && !cmd_accept;

    always_comb
    begin
        prdata = '0;
        if (status_sel)
        begin
            // nack and read data land in the status regs one cycle after done
            prdata[status_busy_bit] = busy || start || done;
            prdata[status_nack_bit] = nack_q;
            prdata[status_rdata_msb:status_rdata_lsb] = rd_data_q;
        end
        else if (cmd_sel)
        begin
            prdata[cmd_addr_msb:cmd_addr_lsb]   = mem_addr;
            prdata[cmd_wdata_msb:cmd_wdata_lsb] = wr_data;
            prdata[cmd_op_bit]                  = rnw;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            start     <= 1'b0;
            nack_q    <= 1'b0;
            rd_data_q <= 8'h00;
        end
        else
        begin
            start <= cmd_accept;
            if (cmd_accept)
                nack_q <= 1'b0;        // cleared by the next accepted command
            else if (done)
                nack_q <= nack;
            if (done)
                rd_data_q <= rd_data;
        end
    end

    // command fields
    always_ff @(posedge CLK)
    begin
        if (cmd_accept)
        begin
            mem_addr <= pwdata[cmd_addr_msb:cmd_addr_lsb];
            wr_data  <= pwdata[cmd_wdata_msb:cmd_wdata_lsb];
            rnw      <= pwdata[cmd_op_bit];
        end
    end

    a_no_start_busy: assert property (@(posedge CLK) disable iff (RESET)
        start |-> !busy);

endmodule

// ==== apb_regs_pkg.sv ====
package apb_regs_pkg;

    // byte offsets
    localparam int unsigned reg_cmd_offset    = 'h0;
    localparam int unsigned reg_status_offset = 'h4;

    // CMD fields
    localparam int cmd_addr_lsb  = 0;
    localparam int cmd_addr_msb  = 10;
    localparam int cmd_wdata_lsb = 11;
    localparam int cmd_wdata_msb = 18;
    localparam int cmd_op_bit    = 24; // 1 = read

    // STATUS fields
    localparam int status_busy_bit  = 0;
    localparam int status_nack_bit  = 1;
    localparam int status_rdata_lsb = 8;
    localparam int status_rdata_msb = 15;

endpackage

// ==== eeprom_bus_pkg.sv ====
package eeprom_bus_pkg;

    // line driver operations
    localparam logic [1:0] op_start      = 2'd0;
    localparam logic [1:0] op_stop       = 2'd1;
    localparam logic [1:0] op_write_byte = 2'd2; // byte out, ack sampled
    localparam logic [1:0] op_read_byte  = 2'd3; // byte in, master ack driven

    localparam logic [3:0] dev_type_code = 4'b1010;

    // one byte on the wire, seen as control byte or as plain data
    typedef union packed {
        struct packed {
            logic [3:0] dev_type;
            logic [2:0] page;     // memory address bits 10..8
            logic       rnw;      // 1 for read
        } ctrl;
        logic [7:0] raw;
    } bus_byte_u;

endpackage

// ==== eeprom_ctrl_top.sv ====
`timescale 1ns/1ns
module eeprom_ctrl_top #(
    parameter int CLK_DIV    = 4,
    parameter int APB_ADDR_W = 4
) (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [APB_ADDR_W-1:0] paddr,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr,
    output logic                  scl,
    output logic                  sda_low,   // open drain, 1 pulls sda low
    input  logic                  sda_in
);
    import eeprom_bus_pkg::*;

    logic        start;
    logic        rnw;
    logic [10:0] mem_addr;
    logic [7:0]  wr_data;
    logic        busy;
    logic        done;
    logic        nack;
    logic [7:0]  rd_data;
    logic        op_valid;
    logic        op_ready;
    logic [1:0]  op_code;
    bus_byte_u   op_byte;
    logic        op_master_ack;
    logic        op_done;
    logic [7:0]  rx_byte;
    logic        rx_ack;

    apb_eeprom_regs #(
        .APB_ADDR_W (APB_ADDR_W)
    ) i_regs (
        .CLK      (CLK),
        .RESET    (RESET),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .busy     (busy),
        .done     (done),
        .nack     (nack),
        .rd_data  (rd_data),
        .start    (start),
        .rnw      (rnw),
        .mem_addr (mem_addr),
        .wr_data  (wr_data)
    );

    eeprom_sequencer i_seq (
        .CLK           (CLK),
        .RESET         (RESET),
        .start         (start),
        .rnw           (rnw),
        .mem_addr      (mem_addr),
        .wr_data       (wr_data),
        .busy          (busy),
        .done          (done),
        .nack          (nack),
        .rd_data       (rd_data),
        .op_valid      (op_valid),
        .op_code       (op_code),
        .op_byte       (op_byte),
        .op_master_ack (op_master_ack),
        .op_ready      (op_ready),
        .op_done       (op_done),
        .rx_byte       (rx_byte),
        .rx_ack        (rx_ack)
    );

    serial_line_driver #(
        .CLK_DIV (CLK_DIV)
    ) i_line (
        .CLK           (CLK),
        .RESET         (RESET),
        .op_valid      (op_valid),
        .op_code       (op_code),
        .op_byte       (op_byte),
        .op_master_ack (op_master_ack),
        .op_ready      (op_ready),
        .op_done       (op_done),
        .rx_byte       (rx_byte),
        .rx_ack        (rx_ack),
        .scl           (scl),
        .sda_low       (sda_low),
        .sda_in        (sda_in)
    );

endmodule

// ==== eeprom_model.sv ====
`timescale 1ns/1ns
module eeprom_model (
    input  logic scl,
    input  logic sda,
    input  logic refuse_ack,
    output logic sda_low
);
    logic [7:0] mem [0:2047];
    logic [7:0] rx;
    logic [7:0] tx;
    logic [7:0] last_ctrl;
    logic [2:0] page;
    logic [7:0] addr_lo;
    logic       sending;
    logic       read_pending;
    logic       master_nack;
    int         bitcnt;
    int         byte_idx;
    int         n_start;
    int         n_stop;
    int         n_bytes;
    int         bad_ctrl;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'(i ^ (i >> 3) ^ 8'h5a); // every address bit shows up
        sda_low = 1'b0;
        {sending, read_pending, master_nack} = 3'b000;
        bitcnt   = 0;
        byte_idx = 0;
        n_start  = 0;
        n_stop   = 0;
        n_bytes  = 0;
        bad_ctrl = 0;
        {page, addr_lo, last_ctrl} = '0;
    end

    always @(negedge sda)
    begin
        if (scl)
        begin
            n_start++;          // start or repeated start
            bitcnt      = 0;
            byte_idx    = 0;
            sending     = 1'b0;
            master_nack = 1'b0;
            sda_low     = 1'b0;
        end
    end

    always @(posedge sda)
        if (scl)
            n_stop++;

    always @(posedge scl)
    begin
        if (bitcnt < 8)
            rx = {rx[6:0], sda};
        else if (sending)
            master_nack = sda; // master's ack bit on a read
        if (bitcnt < 9)
            bitcnt++;
    end

    always @(negedge scl)
    begin
        if (bitcnt == 9)
        begin
            bitcnt       = 0;
            sda_low      = 1'b0;
            sending      = read_pending;
            read_pending = 1'b0;
            tx           = mem[{page, addr_lo}];
        end
        else if (bitcnt == 8)
        begin
            if (sending)
                sda_low = 1'b0;  // let the master answer
            else
            begin
                n_bytes++;
                if (!refuse_ack)
                begin
                    sda_low = 1'b1;
                    case (byte_idx)
                        0:
                        begin
                            last_ctrl = rx;
                            if (rx[7:4] != 4'b1010)
                                bad_ctrl++;
                            page         = rx[3:1];
                            read_pending = rx[0];
                        end
                        1: addr_lo = rx;
                        2: mem[{page, addr_lo}] = rx;
                        default: ;
                    endcase
                    byte_idx++;
                end
            end
        end
        if (sending && bitcnt < 8)
            sda_low = !tx[7 - bitcnt];
    end

endmodule

// ==== eeprom_sequencer.sv ====
`timescale 1ns/1ns
module eeprom_sequencer (
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic                      start,
    input  logic                      rnw,
    input  logic [10:0]               mem_addr,
    input  logic [7:0]                wr_data,
    output logic                      busy,
    output logic                      done,
    output logic                      nack,
    output logic [7:0]                rd_data,
    output logic                      op_valid,
    output logic [1:0]                op_code,
    output eeprom_bus_pkg::bus_byte_u op_byte,
    output logic                      op_master_ack,
    input  logic                      op_ready,
    input  logic                      op_done,
    input  logic [7:0]                rx_byte,
    input  logic                      rx_ack
);
    import eeprom_bus_pkg::*;

    // one-hot state bits
    localparam int st_idle        = 0;
    localparam int st_write_start = 1;
    localparam int st_ctrl_write  = 2;
    localparam int st_addr_write  = 3;
    localparam int st_data_write  = 4;
    localparam int st_read_start  = 5;
    localparam int st_ctrl_read   = 6;
    localparam int st_data_read   = 7;
    localparam int st_stop        = 8;

    logic [8:0] state;
    logic       byte_sent;

    assign busy = !state[st_idle];

    // single byte read, so the master always NACKs
    assign op_master_ack = 1'b0;

    assign byte_sent = state[st_ctrl_write] || state[st_addr_write]
                    || state[st_data_write] || state[st_ctrl_read];

    function automatic logic [7:0] ctrl_byte(input logic [2:0] page, input logic rd);
        bus_byte_u b;
        b.ctrl.dev_type = dev_type_code;
        b.ctrl.page     = page;
        b.ctrl.rnw      = rd;
        return b.raw;
    endfunction

    // hand the next line operation out and move on
    task automatic issue(input logic [1:0] code, input logic [7:0] raw, input int nxt);
        op_valid    <= 1'b1;
        op_code     <= code;
        op_byte.raw <= raw;
        state       <= 9'(1) << nxt;
    endtask

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= 9'(1) << st_idle;
            op_valid <= 1'b0;
            done     <= 1'b0;
            nack     <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (op_valid && op_ready)
                op_valid <= 1'b0;

            if (state[st_idle])
            begin
                if (start)
                begin
                    nack <= 1'b0;
                    issue(op_start, 8'h00, st_write_start);
                end
            end
            else if (op_done)
            begin
                if (byte_sent && !rx_ack)
                begin
                    nack <= 1'b1;      // nobody answered, abort
                    issue(op_stop, 8'h00, st_stop);
                end
                else
                begin
                    unique case (1'b1)
                        state[st_write_start]:
                            issue(op_write_byte, ctrl_byte(mem_addr[10:8], 1'b0), st_ctrl_write);
                        state[st_ctrl_write]:
                            issue(op_write_byte, mem_addr[7:0], st_addr_write);
                        state[st_addr_write]:
                            if (rnw)
                                issue(op_start, 8'h00, st_read_start); // repeated start
                            else
                                issue(op_write_byte, wr_data, st_data_write);
                        state[st_data_write]:
                            issue(op_stop, 8'h00, st_stop);
                        state[st_read_start]:
                            issue(op_write_byte, ctrl_byte(mem_addr[10:8], 1'b1), st_ctrl_read);
                        state[st_ctrl_read]:
                            issue(op_read_byte, 8'h00, st_data_read);
                        state[st_data_read]:
                        begin
                            rd_data <= rx_byte;
                            issue(op_stop, 8'h00, st_stop);
                        end
                        state[st_stop]:
                        begin
                            state <= 9'(1) << st_idle;
                            done  <= 1'b1;
                        end
                        default:
                            state <= 9'(1) << st_idle;
                    endcase
                end
            end
        end
    end

    a_op_hold: assert property (@(posedge CLK) disable iff (RESET)
        op_valid && !op_ready |=> op_valid && $stable(op_code) && $stable(op_byte));

    a_ctrl_dev_type: assert property (@(posedge CLK) disable iff (RESET)
        op_valid && (state[st_ctrl_write] || state[st_ctrl_read])
        |-> op_byte.ctrl.dev_type == dev_type_code);

endmodule

// ==== serial_line_driver.sv ====
`timescale 1ns/1ns
module serial_line_driver #(
    parameter int CLK_DIV = 4
) (
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic                      op_valid,
    input  logic [1:0]                op_code,
    input  eeprom_bus_pkg::bus_byte_u op_byte,
    input  logic                      op_master_ack,
    output logic                      op_ready,
    output logic                      op_done,
    output logic [7:0]                rx_byte,
    output logic                      rx_ack,
    output logic                      scl,
    output logic                      sda_low,
    input  logic                      sda_in
);
    import eeprom_bus_pkg::*;

    localparam int QW = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    logic          active;
    logic [QW-1:0] qcnt;      // cycles within a quarter
    logic [1:0]    phase;     // quarter within a bit
    logic [3:0]    bit_idx;   // 8 is the ack bit
    logic [1:0]    code_q;
    logic          mack_q;
    logic [7:0]    shift_q;
    logic          quarter_end;
    logic          is_byte;
    logic          last_bit;

    assign quarter_end = qcnt == QW'(CLK_DIV - 1);
    assign is_byte     = (code_q == op_write_byte) || (code_q == op_read_byte);
    assign last_bit    = !is_byte || (bit_idx == 4'd8);
    assign op_ready    = !active;
    assign rx_byte     = shift_q;

    // {scl, sda_low} for the given quarter
    function automatic logic [1:0] line_levels(input logic [1:0] code, input logic [1:0] ph,
            input logic [3:0] bidx, input logic tx_bit, input logic mack,
            input logic scl_now, input logic sda_now);
        logic scl_n;
        logic sda_n;
        scl_n = scl_now;
        sda_n = sda_now;
        case (code)
            op_start:
            begin
                sda_n = (ph == 2'd2) || (ph == 2'd3);       // falls with scl high
                scl_n = (ph == 2'd0) ? scl_now : (ph != 2'd3);
            end
            op_stop:
            begin
                sda_n = (ph != 2'd3);                         // rises with scl high
                scl_n = (ph != 2'd0);
            end
            default:
            begin
                scl_n = (ph == 2'd1) || (ph == 2'd2);
                if (ph == 2'd0)
                begin
                    if (bidx == 4'd8)
                        sda_n = (code == op_read_byte) && mack;
                    else
                        sda_n = (code == op_write_byte) && !tx_bit;
                end
            end
        endcase
        return {scl_n, sda_n};
    endfunction

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active  <= 1'b0;
            op_done <= 1'b0;
            rx_ack  <= 1'b0;
            scl     <= 1'b1;
            sda_low <= 1'b0;
            qcnt    <= '0;
            phase   <= 2'd0;
            bit_idx <= 4'd0;
        end
        else
        begin
            op_done <= 1'b0;
            if (!active)
            begin
                if (op_valid)
                begin
                    active  <= 1'b1;
                    qcnt    <= '0;
                    phase   <= 2'd0;
                    bit_idx <= 4'd0;
                    {scl, sda_low} <= line_levels(op_code, 2'd0, 4'd0, op_byte.raw[7],
                                                  op_master_ack, scl, sda_low);
                end
            end
            else if (!quarter_end)
                qcnt <= qcnt + 1'b1;
            else
            begin
                qcnt  <= '0;
                phase <= phase + 2'd1;
                if (is_byte && phase == 2'd1 && bit_idx == 4'd8)
                    rx_ack <= !sda_in;    // mid scl high
                if (phase == 2'd3)
                begin
                    if (last_bit)
                    begin
                        active  <= 1'b0;
                        op_done <= 1'b1;
                    end
                    else
                    begin
                        bit_idx <= bit_idx + 4'd1;
                        {scl, sda_low} <= line_levels(code_q, 2'd0, bit_idx + 4'd1, shift_q[7],
                                                      mack_q, scl, sda_low);
                    end
                end
                else
                    {scl, sda_low} <= line_levels(code_q, phase + 2'd1, bit_idx, shift_q[7],
                                                  mack_q, scl, sda_low);
            end
        end
    end

    // shifts out on msb, samples in on lsb at the same point
    always_ff @(posedge CLK)
    begin
        if (!active && op_valid)
        begin
            code_q  <= op_code;
            mack_q  <= op_master_ack;
            shift_q <= op_byte.raw;
        end
        else if (active && quarter_end && phase == 2'd1 && is_byte && bit_idx < 4'd8)
            shift_q <= {shift_q[6:0], sda_in};
    end

    a_sda_scl_low: assert property (@(posedge CLK) disable iff (RESET)
        is_byte && $changed(sda_low) |-> !scl && !$past(scl));

endmodule

// ==== src.f ====
eeprom_bus_pkg.sv
apb_regs_pkg.sv
apb_eeprom_regs.sv
eeprom_sequencer.sv
serial_line_driver.sv
eeprom_ctrl_top.sv
eeprom_model.sv
tb_eeprom_ctrl.sv

// ==== tb_eeprom_ctrl.sv ====
`timescale 1ns/1ns
module tb_eeprom_ctrl;
    import eeprom_bus_pkg::*;
    import apb_regs_pkg::*;

    localparam int CLK_DIV    = 4;
    localparam int APB_ADDR_W = 4;
    localparam int drive_dly  = 10;
    localparam int txn_cycles = 1300;                 // one transaction at CLK_DIV 4
    localparam int max_cycles = 8 * txn_cycles + 9600;

    logic        CLK, RESET, psel, penable, pwrite, refuse_ack;
    logic [APB_ADDR_W-1:0] paddr;
    logic [31:0] pwdata;
    wire  [31:0] prdata;
    wire         pready, pslverr, scl, sda_low_dut, sda_low_mdl, sda;

    integer      seed;
    int          errors, checks, cycles;
    int          starts_before, stops_before, bytes_before;
    logic [10:0] exp_addr;
    logic [7:0]  ref_mem [0:2047];
    logic [7:0]  exp_data, exp_ctrl;
    logic [31:0] status_q;
    logic        slverr_q, first_err;
    logic        chk_reset, chk_write, chk_read, chk_busy, chk_refuse;
    logic [31:0] rnd;
    logic [10:0] addr;

    assign sda = !(sda_low_dut || sda_low_mdl); // open drain wire

    eeprom_ctrl_top #(.CLK_DIV(CLK_DIV), .APB_ADDR_W(APB_ADDR_W)) i_dut (
        .CLK(CLK), .RESET(RESET), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .scl(scl), .sda_low(sda_low_dut), .sda_in(sda)
    );

    eeprom_model i_model (.scl(scl), .sda(sda), .refuse_ack(refuse_ack), .sda_low(sda_low_mdl));

    initial
    begin
        CLK = 1'b0;
        forever #50 CLK = !CLK;
    end

    task automatic report_fail(input string msg);
        errors++;
        $display("Fail %0t: %s", $time, msg);
    endtask

    a_reset: assert property (@(posedge CLK) chk_reset |->
        scl && !sda_low_dut && status_q[1:0] == 2'b00)
        else report_fail("idle lines or status wrong after reset");
    a_write: assert property (@(posedge CLK) chk_write |->
        i_model.mem[exp_addr] == exp_data && !status_q[1] && !slverr_q
        && i_model.last_ctrl == exp_ctrl && i_model.bad_ctrl == 0
        && i_model.n_start - starts_before == 1 && i_model.n_stop - stops_before == 1)
        else report_fail("write transaction wrong");
    a_read: assert property (@(posedge CLK) chk_read |->
        status_q[15:8] == exp_data && !status_q[1] && i_model.last_ctrl == exp_ctrl
        && i_model.master_nack && i_model.n_start - starts_before == 2
        && i_model.n_stop - stops_before == 1)
        else report_fail("read transaction wrong");
    a_busy: assert property (@(posedge CLK) chk_busy |->
        !first_err && slverr_q && i_model.mem[exp_addr] == exp_data
        && i_model.n_start - starts_before == 1 && i_model.n_stop - stops_before == 1)
        else report_fail("command while busy not refused cleanly");
    a_refuse: assert property (@(posedge CLK) chk_refuse |->
        status_q[1:0] == 2'b10 && i_model.mem[exp_addr] == exp_data
        && i_model.n_bytes - bytes_before == 1 && i_model.n_stop - stops_before == 1)
        else report_fail("missing acknowledge not handled");
    a_pready: assert property (@(posedge CLK) disable iff (RESET)
        psel && penable |-> pready)
        else report_fail("pready low in an access phase");
    a_sda_stable: assert property (@(posedge CLK) disable iff (RESET)
        scl && $past(scl) && $changed(sda) |->
        i_dut.i_line.active
        && (i_dut.i_line.code_q == op_start || i_dut.i_line.code_q == op_stop))
        else report_fail("sda moved while scl high outside start and stop");

    always @(posedge CLK)
    begin
        cycles++;
        if (cycles >= max_cycles)
        begin
            $display("timeout after %0d cycles, a transaction never finished", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] cmd_word(input logic rd, input logic [10:0] a,
            input logic [7:0] d);
        logic [31:0] w;
        w = '0;
        w[cmd_addr_msb:cmd_addr_lsb]   = a;
        w[cmd_wdata_msb:cmd_wdata_lsb] = d;
        w[cmd_op_bit]                  = rd;
        return w;
    endfunction

    task automatic apb_write(input int offs, input logic [31:0] data, output logic err);
        @(posedge CLK);
        #drive_dly;
        {psel, pwrite, penable} = 3'b110;
        paddr  = APB_ADDR_W'(offs);
        pwdata = data;
        @(posedge CLK);
        #drive_dly;
        penable = 1'b1;
        @(negedge CLK);
        err = pslverr;
        @(posedge CLK);
        #drive_dly;
        {psel, pwrite, penable} = 3'b000;
    endtask

    task automatic apb_read(input int offs, output logic [31:0] data);
        @(posedge CLK);
        #drive_dly;
        {psel, pwrite, penable} = 3'b100;
        paddr = APB_ADDR_W'(offs);
        @(posedge CLK);
        #drive_dly;
        penable = 1'b1;
        @(negedge CLK);
        data = prdata;
        @(posedge CLK);
        #drive_dly;
        {psel, penable} = 2'b00;
    endtask

    task automatic wait_idle();
        do
            apb_read(reg_status_offset, status_q);
        while (status_q[status_busy_bit]);
    endtask

    task automatic snapshot();
        starts_before = i_model.n_start;
        stops_before  = i_model.n_stop;
        bytes_before  = i_model.n_bytes;
    endtask

    // one cycle for the armed checks to be sampled
    task automatic end_check();
        checks++;
        @(posedge CLK);
        #drive_dly;
        {chk_reset, chk_write, chk_read, chk_busy, chk_refuse} = '0;
    endtask

    task automatic run_write(input logic [10:0] a, input logic [7:0] d);
        snapshot();
        apb_write(reg_cmd_offset, cmd_word(1'b0, a, d), slverr_q);
        ref_mem[a] = d;
        wait_idle();
        exp_addr  = a;
        exp_data  = d;
        exp_ctrl  = {4'b1010, a[10:8], 1'b0};
        chk_write = 1'b1;
        end_check();
    endtask

    task automatic run_read(input logic [10:0] a);
        snapshot();
        apb_write(reg_cmd_offset, cmd_word(1'b1, a, 8'h00), slverr_q);
        wait_idle();
        exp_data = ref_mem[a];
        exp_ctrl = {4'b1010, a[10:8], 1'b1};
        chk_read = 1'b1;
        end_check();
    endtask

    initial
    begin
        {psel, penable, pwrite, refuse_ack} = 4'b0000;
        paddr  = '0;
        pwdata = '0;
        {chk_reset, chk_write, chk_read, chk_busy, chk_refuse} = '0;
        errors = 0;
        checks = 0;
        cycles = 0;
        seed  = 53620;
        RESET = 1'b1;
        repeat (3) @(posedge CLK);
        #drive_dly;
        RESET = 1'b0;

        apb_read(reg_status_offset, status_q);
        chk_reset = 1'b1;
        end_check();

        for (int i = 0; i < 3; i++)
        begin
            rnd  = $random(seed);
            addr = rnd[10:0];
            run_write(addr, rnd[23:16]);
            run_read(addr);
        end

        // second command lands while the first still runs
        rnd  = $random(seed);
        addr = rnd[10:0];
        snapshot();
        apb_write(reg_cmd_offset, cmd_word(1'b0, addr, rnd[23:16]), first_err);
        apb_write(reg_cmd_offset, cmd_word(1'b0, addr, ~rnd[23:16]), slverr_q);
        ref_mem[addr] = rnd[23:16];
        wait_idle();
        exp_addr = addr;
        exp_data = rnd[23:16];
        chk_busy = 1'b1;
        end_check();

        refuse_ack = 1'b1;
        exp_data   = i_model.mem[addr];
        snapshot();
        apb_write(reg_cmd_offset, cmd_word(1'b0, addr, rnd[31:24]), slverr_q);
        wait_idle();
        chk_refuse = 1'b1;
        end_check();
        refuse_ack = 1'b0;

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule
